// File: all.f
+incdir+hdl
hdl/gpu_pkg.sv
hdl/gpu_reg_file.sv
hdl/gpu_ucode_rom.sv
hdl/gpu_sequencer.sv
hdl/gpu_bg_line.sv
hdl/gpu.sv
tb/gpu_tb.sv

// File: hdl/gpu.sv
`timescale 1ns/1ns
`include "gpu_consts.svh"

module gpu
(
  input  logic                       iClock,
  input  logic                       rstN,
  input  logic                       mcuWe,
  input  logic [2:0]                 mcuRegSelect,
  input  logic [7:0]                 mcuWriteData,
  output logic [`GPU_DATA_WIDTH-1:0] vramAddr,
  output logic                       vramReadRequest,
  input  logic [7:0]                 vramReadData,
  output logic                       fbWe,
  output logic [`GPU_DATA_WIDTH-1:0] fbAddr,
  output logic [`GPU_DATA_WIDTH-1:0] fbData,
  output logic [7:0]                 lcdc,
  output logic [7:0]                 stat,
  output logic [7:0]                 ly,
  output logic [7:0]                 lyc,
  output logic [7:0]                 bgp
);
  import gpu_pkg::*;

  logic [`GPU_IP_WIDTH-1:0]   ip;
  logic [`GPU_UOP_WIDTH-1:0]  uop;
  logic                       gpuWe;
  gpuReg                      gpuDst;
  logic [`GPU_DATA_WIDTH-1:0] gpuResult;
  gpuReg                      op0Sel;
  gpuReg                      op1Sel;
  logic [`GPU_DATA_WIDTH-1:0] op0;
  logic [`GPU_DATA_WIDTH-1:0] op1;
  logic [`GPU_DATA_WIDTH-1:0] mcuAddr;
  logic [7:0]                 bh;
  logic [7:0]                 bl;
  logic                       bgWe;

  // Video memory is addressed straight from the MCU address register
  assign vramAddr = mcuAddr;
  assign fbAddr   = {8'h00, ly};

  gpu_reg_file regFile
  (
    .iClock(iClock), .rstN(rstN),
    .mcuWe(mcuWe), .mcuRegSelect(mcuRegSelect), .mcuWriteData(mcuWriteData),
    .gpuWe(gpuWe), .gpuDst(gpuDst), .gpuResult(gpuResult),
    .op0Sel(op0Sel), .op1Sel(op1Sel), .vramReadData(vramReadData),
    .op0(op0), .op1(op1),
    .lcdc(lcdc), .stat(stat), .ly(ly), .lyc(lyc), .bgp(bgp),
    .mcuAddr(mcuAddr), .bh(bh), .bl(bl)
  );

  gpu_ucode_rom ucodeRom
  (
    .ip(ip),
    .uop(uop)
  );

  gpu_sequencer sequencer
  (
    .iClock(iClock), .rstN(rstN), .lcdc(lcdc), .uop(uop), .op0(op0), .op1(op1),
    .ip(ip), .gpuWe(gpuWe), .gpuDst(gpuDst), .gpuResult(gpuResult),
    .op0Sel(op0Sel), .op1Sel(op1Sel),
    .bgWe(bgWe), .fbWe(fbWe), .vramReadRequest(vramReadRequest)
  );

  gpu_bg_line bgLine
  (
    .iClock(iClock), .rstN(rstN), .bgWe(bgWe),
    .bh(bh), .bl(bl), .bgp(bgp),
    .pixelWord(fbData)
  );

endmodule

// File: hdl/gpu_bg_line.sv
`timescale 1ns/1ns
`include "gpu_consts.svh"

module gpu_bg_line
(
  input  logic                       iClock,
  input  logic                       rstN,
  input  logic                       bgWe,
  input  logic [7:0]                 bh,
  input  logic [7:0]                 bl,
  input  logic [7:0]                 bgp,
  output logic [`GPU_DATA_WIDTH-1:0] pixelWord
);

  logic [1:0]                 pixelIndex;
  logic [`GPU_DATA_WIDTH-1:0] converted;

  // Leftmost pixel comes from bit 7 of both planes and lands in the top bits
  always_comb
  begin
    pixelIndex = 2'b00;
    converted  = '0;
    for (int i = 0; i < 8; i++)
    begin
      pixelIndex = {bh[7-i], bl[7-i]};
      converted[15-2*i -: 2] = bgp[2*pixelIndex +: 2];
    end
  end

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      pixelWord <= '0;
    end
    else if (bgWe)
    begin
      pixelWord <= converted;
    end
  end

endmodule

// File: hdl/gpu_consts.svh
`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Microinstruction word and instruction pointer
`define GPU_UOP_WIDTH 20
`define GPU_IP_WIDTH 6

// Register file and ALU width
`define GPU_DATA_WIDTH 16

//////////////////////////////
// Video memory layout
//////////////////////////////

// Tile data base, selected by LCDC bit 4
`define GPU_TILE_BASE_LO 16'h8000
`define GPU_TILE_BASE_HI 16'h8800

// Visible lines per frame
`define GPU_LINE_COUNT 144

`endif

// File: hdl/gpu_pkg.sv
package gpu_pkg;

  // Microinstruction opcodes, bits 19 to 15 of the word
  typedef enum logic [4:0] {
    opNop   = 5'd0,
    opWbg   = 5'd1,
    opWfb   = 5'd2,
    opWrr   = 5'd3,
    opWrl   = 5'd4,
    opRvmem = 5'd5,
    opAdd   = 5'd6,
    opSub   = 5'd7,
    opShl   = 5'd8,
    opAddl  = 5'd9,
    opSubl  = 5'd10,
    opJnz   = 5'd11,
    opJz    = 5'd12,
    opGoto  = 5'd13
  } gpuOp;

  // Register selects; the last two are read-only sources
  typedef enum logic [4:0] {
    regLcdc     = 5'd0,
    regStat     = 5'd1,
    regLy       = 5'd2,
    regLyc      = 5'd3,
    regBgp      = 5'd4,
    regMcuAddr  = 5'd5,
    regBh       = 5'd6,
    regBl       = 5'd7,
    regR0       = 5'd8,
    regR1       = 5'd9,
    srcTileBase = 5'd10,
    srcVramData = 5'd11
  } gpuReg;

endpackage

// File: hdl/gpu_reg_file.sv
`timescale 1ns/1ns
`include "gpu_consts.svh"

module gpu_reg_file
(
  input  logic                       iClock,
  input  logic                       rstN,
  input  logic                       mcuWe,
  input  logic [2:0]                 mcuRegSelect,
  input  logic [7:0]                 mcuWriteData,
  input  logic                       gpuWe,
  input  gpu_pkg::gpuReg             gpuDst,
  input  logic [`GPU_DATA_WIDTH-1:0] gpuResult,
  input  gpu_pkg::gpuReg             op0Sel,
  input  gpu_pkg::gpuReg             op1Sel,
  input  logic [7:0]                 vramReadData,
  output logic [`GPU_DATA_WIDTH-1:0] op0,
  output logic [`GPU_DATA_WIDTH-1:0] op1,
  output logic [7:0]                 lcdc,
  output logic [7:0]                 stat,
  output logic [7:0]                 ly,
  output logic [7:0]                 lyc,
  output logic [7:0]                 bgp,
  output logic [`GPU_DATA_WIDTH-1:0] mcuAddr,
  output logic [7:0]                 bh,
  output logic [7:0]                 bl
);
  import gpu_pkg::*;

  gpuReg                      mcuSel;
  logic [1:0]                 statMode;
  logic [`GPU_DATA_WIDTH-1:0] r0;
  logic [`GPU_DATA_WIDTH-1:0] r1;
  logic [`GPU_DATA_WIDTH-1:0] tileBase;

  // CPU select shares the low encodings of the register select
  assign mcuSel   = gpuReg'({2'b00, mcuRegSelect});
  assign tileBase = lcdc[4] ? `GPU_TILE_BASE_LO : `GPU_TILE_BASE_HI;

  // Bit 2 is the LY/LYC coincidence flag
  assign stat = {5'b00000, (ly == lyc), statMode};

  //////////////////////////////
  // Register writes
  //////////////////////////////

  // The sequencer write comes last so it overrides a CPU write to the same register
  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      lcdc     <= 8'h00;
      statMode <= 2'b00;
      ly       <= 8'h00;
      lyc      <= 8'h00;
      bgp      <= 8'h00;
      mcuAddr  <= '0;
      bh       <= 8'h00;
      bl       <= 8'h00;
      r0       <= '0;
      r1       <= '0;
    end
    else
    begin
      if (mcuWe)
      begin
        case (mcuSel)
          regLcdc: lcdc <= mcuWriteData;
          regLyc:  lyc  <= mcuWriteData;
          regBgp:  bgp  <= mcuWriteData;
          default: ;
        endcase
      end
      if (gpuWe)
      begin
        case (gpuDst)
          regLcdc:    lcdc     <= gpuResult[7:0];
          regStat:    statMode <= gpuResult[1:0];
          regLy:      ly       <= gpuResult[7:0];
          regLyc:     lyc      <= gpuResult[7:0];
          regBgp:     bgp      <= gpuResult[7:0];
          regMcuAddr: mcuAddr  <= gpuResult;
          regBh:      bh       <= gpuResult[7:0];
          regBl:      bl       <= gpuResult[7:0];
          regR0:      r0       <= gpuResult;
          regR1:      r1       <= gpuResult;
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // Operand read ports
  //////////////////////////////

  function automatic logic [`GPU_DATA_WIDTH-1:0] readReg(gpuReg sel);
    case (sel)
      regLcdc:     return {8'h00, lcdc};
      regStat:     return {8'h00, stat};
      regLy:       return {8'h00, ly};
      regLyc:      return {8'h00, lyc};
      regBgp:      return {8'h00, bgp};
      regMcuAddr:  return mcuAddr;
      regBh:       return {8'h00, bh};
      regBl:       return {8'h00, bl};
      regR0:       return r0;
      regR1:       return r1;
      srcTileBase: return tileBase;
      srcVramData: return {8'h00, vramReadData};
      default:     return '0;
    endcase
  endfunction

  assign op0 = readReg(op0Sel);
  assign op1 = readReg(op1Sel);

endmodule

// File: hdl/gpu_sequencer.sv
`timescale 1ns/1ns
`include "gpu_consts.svh"

module gpu_sequencer
(
  input  logic                       iClock,
  input  logic                       rstN,
  input  logic [7:0]                 lcdc,
  input  logic [`GPU_UOP_WIDTH-1:0]  uop,
  input  logic [`GPU_DATA_WIDTH-1:0] op0,
  input  logic [`GPU_DATA_WIDTH-1:0] op1,
  output logic [`GPU_IP_WIDTH-1:0]   ip,
  output logic                       gpuWe,
  output gpu_pkg::gpuReg             gpuDst,
  output logic [`GPU_DATA_WIDTH-1:0] gpuResult,
  output gpu_pkg::gpuReg             op0Sel,
  output gpu_pkg::gpuReg             op1Sel,
  output logic                       bgWe,
  output logic                       fbWe,
  output logic                       vramReadRequest
);
  import gpu_pkg::*;

  gpuOp                       opcode;
  gpuReg                      srcField;
  logic [9:0]                 imm;
  logic [`GPU_DATA_WIDTH-1:0] immExt;
  logic                       active;
  logic                       zeroFlag;
  logic                       regWe;
  logic                       bgStrobe;
  logic                       fbStrobe;
  logic                       readStrobe;
  logic                       jump;

  assign opcode   = gpuOp'(uop[19:15]);
  assign gpuDst   = gpuReg'(uop[14:10]);
  assign srcField = gpuReg'(uop[9:5]);
  assign imm      = uop[9:0];
  assign immExt   = {6'b000000, imm};
  assign active   = lcdc[7];

  // Immediate arithmetic works on the destination register itself
  assign op0Sel = gpuDst;
  assign op1Sel = (opcode == opAddl || opcode == opSubl) ? gpuDst : srcField;

  //////////////////////////////
  // Decode and ALU
  //////////////////////////////

  always_comb
  begin
    gpuResult  = '0;
    regWe      = 1'b0;
    bgStrobe   = 1'b0;
    fbStrobe   = 1'b0;
    readStrobe = 1'b0;
    jump       = 1'b0;
    case (opcode)
      opWbg:   bgStrobe = 1'b1;
      opWfb:   fbStrobe = 1'b1;
      opRvmem: readStrobe = 1'b1;
      opWrr:
      begin
        gpuResult = op1;
        regWe     = 1'b1;
      end
      opWrl:
      begin
        gpuResult = immExt;
        regWe     = 1'b1;
      end
      opAdd:
      begin
        gpuResult = op0 + op1;
        regWe     = 1'b1;
      end
      opSub:
      begin
        gpuResult = op0 - op1;
        regWe     = 1'b1;
      end
      opShl:
      begin
        // Shift amount sits below the source field
        gpuResult = op1 << imm[3:0];
        regWe     = 1'b1;
      end
      opAddl:
      begin
        gpuResult = op1 + immExt;
        regWe     = 1'b1;
      end
      opSubl:
      begin
        gpuResult = op1 - immExt;
        regWe     = 1'b1;
      end
      opJnz:   jump = !zeroFlag;
      opJz:    jump = zeroFlag;
      opGoto:  jump = 1'b1;
      default: ;
    endcase
  end

  // Nothing leaves the sequencer while the display is off
  assign gpuWe           = active & regWe;
  assign bgWe            = active & bgStrobe;
  assign fbWe            = active & fbStrobe;
  assign vramReadRequest = active & readStrobe;

  //////////////////////////////
  // Instruction pointer
  //////////////////////////////

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      ip       <= '0;
      zeroFlag <= 1'b0;
    end
    else if (active)
    begin
      ip <= jump ? imm[`GPU_IP_WIDTH-1:0] : ip + 1'b1;
      if (regWe)
      begin
        zeroFlag <= (gpuResult == '0);
      end
    end
  end

endmodule

// File: hdl/gpu_ucode_rom.sv
`timescale 1ns/1ns
`include "gpu_consts.svh"

module gpu_ucode_rom
(
  input  logic [`GPU_IP_WIDTH-1:0]  ip,
  output logic [`GPU_UOP_WIDTH-1:0] uop
);
  import gpu_pkg::*;

  // Word layout is opcode, destination, then source or a 10-bit immediate
  always_comb
  begin
    case (ip)
      // Line start, mode 3 while the tile row is fetched
      6'd0:  uop = {opWrl, regStat, 10'd3};
      6'd1:  uop = {opWrr, regMcuAddr, srcTileBase, 5'd0};
      // Two bytes per tile row, so the row offset is LY times two
      6'd2:  uop = {opShl, regR0, regLy, 5'd1};
      6'd3:  uop = {opAdd, regMcuAddr, regR0, 5'd0};
      6'd4:  uop = {opRvmem, regLcdc, 10'd0};
      6'd5:  uop = {opWrr, regBl, srcVramData, 5'd0};
      6'd6:  uop = {opAddl, regMcuAddr, 10'd1};
      6'd7:  uop = {opRvmem, regLcdc, 10'd0};
      6'd8:  uop = {opWrr, regBh, srcVramData, 5'd0};
      // Convert the pixels, then push the word out at address LY
      6'd9:  uop = {opWbg, regLcdc, 10'd0};
      6'd10: uop = {opWfb, regLcdc, 10'd0};
      6'd11: uop = {opWrl, regStat, 10'd0};
      6'd12: uop = {opAddl, regLy, 10'd1};
      // R1 ends at zero once the last visible line is done
      6'd13: uop = {opWrr, regR1, regLy, 5'd0};
      6'd14: uop = {opSubl, regR1, 10'(`GPU_LINE_COUNT)};
      6'd15: uop = {opJnz, regLcdc, 10'd0};
      // Vertical blank, then back to line 0
      6'd16: uop = {opWrl, regStat, 10'd1};
      6'd17: uop = {opWrl, regLy, 10'd0};
      6'd18: uop = {opGoto, regLcdc, 10'd0};
      default: uop = {opNop, regLcdc, 10'd0};
    endcase
  end

endmodule

// File: run.sh
#!/bin/sh
# Build the gpu testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f all.f --top-module gpu_tb -o gpu_sim

./obj_dir/gpu_sim | tee sim.log

grep -qx "Simulation passed" sim.log

// File: tb/gpu_tb.sv
`timescale 1ns/1ns
`include "gpu_consts.svh"

module gpu_tb;

  // About four frames of 2307 cycles across all tests, with room to spare
  localparam int maxCycles = 20000;

  logic        iClock;
  logic        rstN;
  logic        mcuWe;
  logic [2:0]  mcuRegSelect;
  logic [7:0]  mcuWriteData;
  logic [15:0] vramAddr;
  logic        vramReadRequest;
  logic [7:0]  vramReadData = 8'h00;
  logic        fbWe;
  logic [15:0] fbAddr;
  logic [15:0] fbData;
  logic [7:0]  lcdc;
  logic [7:0]  stat;
  logic [7:0]  ly;
  logic [7:0]  lyc;
  logic [7:0]  bgp;

  // Reference model of the CPU-visible state and the line walk
  logic [7:0]  lcdcModel = 8'h00;
  logic [7:0]  lycModel = 8'h00;
  logic [7:0]  bgpModel = 8'h00;
  logic [7:0]  lineCount;
  logic [7:0]  curLine;
  logic        readHalf;
  logic        fbSeen = 1'b0;
  logic        reqSeen = 1'b0;
  logic [15:0] addrSeen = 16'h0000;
  logic [15:0] tileBase;
  logic [15:0] expReadAddr;
  logic [15:0] expPixels;
  logic [31:0] rngState = 32'hc63c;
  int          errorCount = 0;
  int          errorsAtStart = 0;
  int          testCount = 0;
  int          testsPassed = 0;
  int          cycleCount = 0;

  gpu gpu_i
  (
    .iClock(iClock), .rstN(rstN),
    .mcuWe(mcuWe), .mcuRegSelect(mcuRegSelect), .mcuWriteData(mcuWriteData),
    .vramAddr(vramAddr), .vramReadRequest(vramReadRequest), .vramReadData(vramReadData),
    .fbWe(fbWe), .fbAddr(fbAddr), .fbData(fbData),
    .lcdc(lcdc), .stat(stat), .ly(ly), .lyc(lyc), .bgp(bgp)
  );

  initial
  begin
    iClock = 1'b0;
    forever #20 iClock = ~iClock;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // Memory contents are the low address byte scrambled
  function automatic logic [7:0] vramByte(input logic [15:0] addr);
    return addr[7:0] ^ 8'h5a;
  endfunction

  function automatic logic [15:0] expectedPixels(input logic [15:0] rowAddr,
                                                 input logic [7:0] pal);
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [1:0]  idx;
    logic [15:0] word;
    lo = vramByte(rowAddr);
    hi = vramByte(rowAddr + 16'd1);
    word = 16'h0000;
    // Pixel 0 is shifted in first and ends up in the top two bits
    for (int i = 0; i < 8; i++)
    begin
      idx = {hi[7 - i], lo[7 - i]};
      word = {word[13:0], pal[2 * idx +: 2]};
    end
    return word;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("mismatch at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
    errorCount++;
  endtask

  task automatic expectEqual(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act == exp) else reportMismatch(name, exp, act);
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge iClock);
    #2;
  endtask

  // The model follows the DUT register right after the edge that latches it
  task automatic writeReg(input logic [2:0] sel, input logic [7:0] data);
    mcuRegSelect = sel;
    mcuWriteData = data;
    mcuWe = 1'b1;
    @(posedge iClock);
    case (sel)
      3'd0: lcdcModel = data;
      3'd3: lycModel = data;
      3'd4: bgpModel = data;
      default: ;
    endcase
    #2;
    mcuWe = 1'b0;
  endtask

  task automatic runToVblank(output int pulses, output int reads);
    pulses = 0;
    reads = 0;
    do
    begin
      @(negedge iClock);
      if (fbWe)
        pulses++;
      if (vramReadRequest)
        reads++;
    end
    while (stat[1:0] != 2'd1);
    waitCycles(1);
  endtask

  task automatic waitForLy(input logic [7:0] target);
    do
      @(negedge iClock);
    while (ly != target);
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errorCount == errorsAtStart)
    begin
      testsPassed++;
      $display("test %0d %s: ok", testCount, name);
    end
    else
      $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsAtStart);
    errorsAtStart = errorCount;
  endtask

  //////////////////////////////
  // Memory and line model
  //////////////////////////////

  assign curLine     = (lineCount == 8'(`GPU_LINE_COUNT)) ? 8'd0 : lineCount;
  assign tileBase    = lcdcModel[4] ? `GPU_TILE_BASE_LO : `GPU_TILE_BASE_HI;
  assign expReadAddr = tileBase + {7'd0, curLine, 1'b0} + {15'd0, readHalf};
  assign expPixels   = expectedPixels(tileBase + {7'd0, curLine, 1'b0}, bgpModel);

  always @(negedge iClock)
  begin
    fbSeen   <= fbWe;
    reqSeen  <= vramReadRequest;
    addrSeen <= vramAddr;
  end

  always @(posedge iClock)
  begin
    if (!rstN)
    begin
      lineCount <= 8'd0;
      readHalf  <= 1'b0;
    end
    else
    begin
      if (fbSeen)
        lineCount <= curLine + 8'd1;
      if (reqSeen)
        readHalf <= !readHalf;
    end
  end

  // Read data shows up on the cycle after the request and holds
  always @(posedge iClock)
  begin
    #2;
    if (reqSeen)
      vramReadData = vramByte(addrSeen);
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  fbAddrOrder: assert property (@(posedge iClock) disable iff (!rstN)
    fbWe |-> fbAddr == {8'h00, curLine})
    else reportMismatch("fbAddr", 32'($sampled(curLine)), 32'($sampled(fbAddr)));

  fbDataRule: assert property (@(posedge iClock) disable iff (!rstN)
    fbWe |-> fbData == expPixels)
    else reportMismatch("fbData", 32'($sampled(expPixels)), 32'($sampled(fbData)));

  readAddrRule: assert property (@(posedge iClock) disable iff (!rstN)
    vramReadRequest |-> vramAddr == expReadAddr)
    else reportMismatch("vramAddr", 32'($sampled(expReadAddr)), 32'($sampled(vramAddr)));

  modeAtWrite: assert property (@(posedge iClock) disable iff (!rstN)
    fbWe |-> stat[1:0] == 2'd3)
    else reportMismatch("stat mode", 32'd3, 32'($sampled(stat[1:0])));

  modeOneInBlank: assert property (@(posedge iClock) disable iff (!rstN)
    stat[1:0] == 2'd1 |-> lineCount == 8'(`GPU_LINE_COUNT))
    else reportMismatch("line count in vblank", 32'(`GPU_LINE_COUNT),
                        32'($sampled(lineCount)));

  coincidenceBit: assert property (@(posedge iClock) disable iff (!rstN)
    stat[2] == (ly == lycModel))
    else reportMismatch("stat[2]", 32'($sampled(ly) == $sampled(lycModel)),
                        32'($sampled(stat[2])));

  statUpperZero: assert property (@(posedge iClock) disable iff (!rstN)
    stat[7:3] == 5'd0)
    else reportMismatch("stat[7:3]", 32'd0, 32'($sampled(stat[7:3])));

  quietWhenOff: assert property (@(posedge iClock) disable iff (!rstN)
    !lcdcModel[7] |-> !fbWe && !vramReadRequest)
    else reportMismatch("fbWe|vramReadRequest", 32'd0,
                        32'({$sampled(fbWe), $sampled(vramReadRequest)}));

  lyHeldWhenOff: assert property (@(posedge iClock) disable iff (!rstN)
    (!lcdcModel[7] && !$past(lcdcModel[7])) |-> $stable(ly))
    else reportMismatch("ly", 32'($past(ly)), 32'($sampled(ly)));

  initial
  begin
    while (cycleCount < maxCycles)
    begin
      @(posedge iClock);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", maxCycles);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial
  begin
    int         pulses;
    int         reads;
    int         strobes;
    logic [7:0] lycVal;
    logic [7:0] heldLy;
    rstN = 1'b0;
    mcuWe = 1'b0;
    mcuRegSelect = 3'd0;
    mcuWriteData = 8'h00;
    repeat (5) @(posedge iClock);
    #2;
    rstN = 1'b1;

    expectEqual("lcdc", 32'h0, 32'(lcdc));
    expectEqual("stat", 32'h4, 32'(stat));
    expectEqual("ly", 32'h0, 32'(ly));
    expectEqual("lyc", 32'h0, 32'(lyc));
    expectEqual("bgp", 32'h0, 32'(bgp));
    waitCycles(10);
    endTest("reset");

    rngState = xorshift(rngState);
    lycVal = 8'(rngState % 144);
    writeReg(3'd3, lycVal);
    expectEqual("lyc", 32'(lycVal), 32'(lyc));
    rngState = xorshift(rngState);
    writeReg(3'd4, rngState[7:0]);
    expectEqual("bgp", 32'(rngState[7:0]), 32'(bgp));
    writeReg(3'd0, 8'h10);
    expectEqual("lcdc", 32'h10, 32'(lcdc));
    writeReg(3'd2, 8'h55);
    expectEqual("ly", 32'h0, 32'(ly));
    endTest("cpu writes");

    writeReg(3'd0, 8'h90);
    runToVblank(pulses, reads);
    expectEqual("fbWe pulses", 32'(`GPU_LINE_COUNT), 32'(pulses));
    endTest("frame at 8000");

    // Base switch lands during vblank, before the next line fetches its base
    writeReg(3'd0, 8'h80);
    rngState = xorshift(rngState);
    writeReg(3'd4, rngState[7:0]);
    runToVblank(pulses, reads);
    expectEqual("fbWe pulses", 32'(`GPU_LINE_COUNT), 32'(pulses));
    expectEqual("vramReadRequest pulses", 32'(2 * `GPU_LINE_COUNT), 32'(reads));
    endTest("frame at 8800");

    rngState = xorshift(rngState);
    lycVal = 8'(rngState % 144);
    writeReg(3'd3, lycVal);
    waitForLy(lycVal);
    expectEqual("stat[2]", 32'd1, 32'(stat[2]));
    runToVblank(pulses, reads);
    expectEqual("fbWe pulses", 32'(`GPU_LINE_COUNT - lycVal), 32'(pulses));
    endTest("stat");

    waitForLy(8'd40);
    waitCycles(1);
    writeReg(3'd0, 8'h00);
    heldLy = ly;
    strobes = 0;
    repeat (50)
    begin
      @(negedge iClock);
      if (fbWe || vramReadRequest)
        strobes++;
    end
    expectEqual("strobes while off", 32'd0, 32'(strobes));
    expectEqual("ly", 32'(heldLy), 32'(ly));
    waitCycles(1);
    writeReg(3'd0, 8'h80);
    runToVblank(pulses, reads);
    expectEqual("fbWe pulses", 32'(`GPU_LINE_COUNT - 40), 32'(pulses));
    endTest("disable");

    $display("tests passed %0d of %0d, errors %0d", testsPassed, testCount, errorCount);
    if (errorCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
